// File: Bender.yml
package:
  name: rv_core

sources:
  - verilog/rv_core_pkg.sv
  - verilog/rv_decoder.sv
  - verilog/rv_regfile.sv
  - verilog/rv_hazard_unit.sv
  - verilog/rv_execute.sv
  - verilog/rv_core.sv
  - target: test
    files:
      - test/rv_core_checker.sv
      - test/rv_core_tb.sv

// File: sim.f
verilog/rv_core_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_hazard_unit.sv
verilog/rv_execute.sv
verilog/rv_core.sv
test/rv_core_checker.sv
test/rv_core_tb.sv

// File: test/rv_core_checker.sv
// memory port protocol assertions, bound into rv_core by the bind statement at the end
`timescale 1ns/1ps

module rv_core_checker #(
    parameter rv_core_pkg::word_t reset_pc = 32'h0000_0000
) (
    input logic               clk,
    input logic               rst_n,
    input rv_core_pkg::word_t imem_addr,
    input logic               dmem_read,
    input logic               dmem_write,
    input rv_core_pkg::word_t dmem_addr,
    input rv_core_pkg::word_t dmem_wdata,
    input logic               dmem_stall
);

    int unsigned fail_count = 0;

    // a stalled MEM request is presented again unchanged
    assert property (@(posedge clk) disable iff (!rst_n)
        dmem_stall |=> $stable(dmem_read) && $stable(dmem_write)
                       && $stable(dmem_addr) && $stable(dmem_wdata))
    else begin
        fail_count++;
        $error("dmem request changed while dmem_stall was high");
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(dmem_read && dmem_write))
    else begin
        fail_count++;
        $error("dmem_read and dmem_write high in the same cycle");
    end

    // covers every reset cycle after the first edge and the first cycle out of reset
    assert property (@(posedge clk)
        !rst_n |=> !dmem_read && !dmem_write && imem_addr == reset_pc)
    else begin
        fail_count++;
        $error("memory ports not in their reset state after a reset edge");
    end

    assert property (@(posedge clk) disable iff (!rst_n) imem_addr[1:0] == 2'b00)
    else begin
        fail_count++;
        $error("imem_addr is not word aligned");
    end

endmodule

bind rv_core rv_core_checker #(.reset_pc(reset_pc)) u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_addr  (imem_addr),
    .dmem_read  (dmem_read),
    .dmem_write (dmem_write),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_stall (dmem_stall)
);

// File: test/rv_core_tb.sv
// testbench for rv_core, runs a fixed program under random memory stalls against an ISA model
`timescale 1ns/1ps

module rv_core_tb;
    import rv_core_pkg::*;

    localparam int mem_words    = 64;
    localparam int stall_pct    = 25;
    localparam int stall_budget = 400;
    localparam int max_steps    = 1000;
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [6:0] f7_sub = 7'b0100000;

    logic   clk;
    logic   rst_n;
    word_t  imem_addr;
    word_t  imem_rdata;
    logic   imem_stall = 1'b0;
    logic   dmem_read;
    logic   dmem_write;
    word_t  dmem_addr;
    word_t  dmem_wdata;
    word_t  dmem_rdata;
    logic   dmem_stall = 1'b0;
    word_t  prog [mem_words];
    word_t  dmem [mem_words];
    word_t  exp_addr [$];
    word_t  exp_data [$];
    int     prog_len = 0;
    int     store_idx = 0;
    int     errors = 0;
    int     cycles = 0;
    int     cycle_limit;
    logic   timed_out;
    integer seed = 9;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    rv_core #(.reset_pc(32'h0000_0000)) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .imem_stall (imem_stall),
        .dmem_read  (dmem_read),
        .dmem_write (dmem_write),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .dmem_stall (dmem_stall)
    );

    // ------------------------------------------------------------------
    // memory models
    // ------------------------------------------------------------------
    // a stalled or idle port returns no valid data
    assign imem_rdata = imem_stall ? 'x : prog[imem_addr[7:2]];
    assign dmem_rdata = (dmem_read && !dmem_stall) ? dmem[dmem_addr[7:2]] : 'x;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (!rst_n) begin
            imem_stall <= 1'b0;
            dmem_stall <= 1'b0;
        end else begin
            imem_stall <= ($unsigned($random(seed)) % 100) < stall_pct;
            dmem_stall <= ($unsigned($random(seed)) % 100) < stall_pct;
        end
    end

    // a store leaves MEM only in a cycle where neither memory stalls
    always @(posedge clk) begin
        if (rst_n && dmem_write && !dmem_stall && !imem_stall) begin
            assert (store_idx < exp_addr.size()) else begin
                errors++;
                $display("store to %h at %0t is beyond the expected sequence", dmem_addr, $time);
            end
            if (store_idx < exp_addr.size()) begin
                assert (dmem_addr == exp_addr[store_idx]) else begin
                    errors++;
                    $display("Mismatch at %0t: dmem_addr got %h expected %h",
                             $time, dmem_addr, exp_addr[store_idx]);
                end
                assert (dmem_wdata == exp_data[store_idx]) else begin
                    errors++;
                    $display("Mismatch at %0t: dmem_wdata got %h expected %h",
                             $time, dmem_wdata, exp_data[store_idx]);
                end
            end
            store_idx++;
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    // ------------------------------------------------------------------
    // instruction encoding and program
    // ------------------------------------------------------------------
    function automatic word_t r_instr(input logic [6:0] f7, input logic [2:0] f3,
                                      input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_rtype};
    endfunction

    function automatic word_t i_instr(input logic [6:0] op, input logic [2:0] f3,
                                      input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic word_t s_instr(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], op_store};
    endfunction

    function automatic word_t b_instr(input logic [2:0] f3, input int rs1, input int rs2,
                                      input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], op_branch};
    endfunction

    task automatic emit(input word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program();
        // dependent ALU chains
        emit(i_instr(op_itype, f3_add, 1, 0, 5));
        emit(i_instr(op_itype, f3_add, 2, 0, 12));
        emit(r_instr(7'b0, f3_add, 3, 1, 2));
        emit(r_instr(f7_sub, f3_add, 4, 3, 1));
        emit(r_instr(7'b0, f3_or, 5, 4, 3));
        emit(r_instr(7'b0, f3_slt, 6, 1, 5));
        emit(s_instr(6, 0, 140));
        emit(r_instr(7'b0, f3_and, 7, 5, 2));
        emit(i_instr(op_itype, f3_add, 8, 0, -3));
        emit(r_instr(7'b0, f3_slt, 9, 8, 1));
        emit(s_instr(3, 0, 128));
        emit(s_instr(7, 0, 132));
        emit(s_instr(9, 0, 136));
        // load-use into ALU and into branches
        emit(i_instr(op_load, f3_lw, 10, 0, 8));
        emit(r_instr(7'b0, f3_add, 11, 10, 1));
        emit(s_instr(11, 0, 144));
        emit(i_instr(op_load, f3_lw, 12, 0, 12));
        emit(b_instr(f3_beq, 12, 0, 8));
        emit(i_instr(op_load, f3_lw, 13, 0, 16));
        emit(b_instr(f3_bne, 13, 12, 8));
        emit(s_instr(1, 0, 148));
        emit(s_instr(13, 0, 152));
        // taken and not-taken on fresh results, then a short backward loop
        emit(i_instr(op_itype, f3_add, 14, 0, 7));
        emit(b_instr(f3_beq, 14, 0, 8));
        emit(s_instr(14, 0, 156));
        emit(r_instr(f7_sub, f3_add, 15, 14, 14));
        emit(b_instr(f3_beq, 15, 0, 8));
        emit(s_instr(1, 0, 160));
        emit(b_instr(f3_bne, 15, 0, 8));
        emit(s_instr(14, 0, 164));
        emit(i_instr(op_itype, f3_add, 16, 0, 3));
        emit(i_instr(op_itype, f3_add, 16, 16, -1));
        emit(s_instr(16, 0, 168));
        emit(b_instr(f3_bne, 16, 0, -8));
        // x0 stays zero
        emit(i_instr(op_itype, f3_add, 0, 0, 99));
        emit(r_instr(7'b0, f3_add, 17, 0, 1));
        emit(s_instr(0, 0, 172));
        emit(s_instr(17, 0, 176));
        emit(i_instr(op_load, f3_lw, 18, 0, 140));
        emit(s_instr(18, 0, 180));
        emit(b_instr(f3_beq, 0, 0, 0));
        // never reached, only a missed flush would store here
        emit(s_instr(1, 0, 184));
    endtask

    // ------------------------------------------------------------------
    // ISA reference model
    // ------------------------------------------------------------------
    function automatic word_t alu_ref(input logic [2:0] f3, input logic is_sub,
                                      input word_t a, input word_t b);
        case (f3)
            3'b000:  return is_sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return a + b;
        endcase
    endfunction

    task automatic run_reference();
        word_t rf [32];
        word_t mem [mem_words];
        word_t ins;
        word_t a;
        word_t b;
        word_t addr;
        word_t imm_b;
        int    pc;
        int    steps;
        logic  done;
        for (int i = 0; i < 32; i++) begin
            rf[i] = '0;
        end
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = dmem[i];
        end
        pc    = 0;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < max_steps) begin
            ins   = prog[pc / 4];
            a     = rf[ins[19:15]];
            b     = rf[ins[24:20]];
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            steps++;
            pc    = pc + 4;
            case (ins[6:0])
                op_rtype: begin
                    rf[ins[11:7]] = alu_ref(ins[14:12], ins[30], a, b);
                end
                op_itype: begin
                    rf[ins[11:7]] = alu_ref(ins[14:12], 1'b0, a, {{20{ins[31]}}, ins[31:20]});
                end
                op_load: begin
                    addr          = a + {{20{ins[31]}}, ins[31:20]};
                    rf[ins[11:7]] = mem[addr[7:2]];
                end
                op_store: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    mem[addr[7:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                op_branch: begin
                    if ((a == b) ^ ins[12]) begin
                        // a taken branch to itself ends the program
                        done = (imm_b == '0);
                        pc   = pc - 4 + $signed(imm_b);
                    end
                end
                default: begin
                end
            endcase
            rf[0] = '0;
        end
    endtask

    // ------------------------------------------------------------------
    // run
    // ------------------------------------------------------------------
    initial begin
        rst_n = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            prog[i] = '0;
            dmem[i] = i * 3 + 5;
        end
        build_program();
        run_reference();
        cycle_limit = 20 * prog_len + stall_budget;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        while (store_idx < exp_addr.size() && cycles < cycle_limit) begin
            @(negedge clk);
        end
        timed_out = (store_idx < exp_addr.size());
        if (timed_out) begin
            $display("timeout after %0d cycles with %0d of %0d stores seen",
                     cycles, store_idx, exp_addr.size());
        end
        // let the final self-loop spin so a stray store still shows up
        repeat (20) @(negedge clk);
        $display("errors: %0d store, %0d protocol, %0d timeout",
                 errors, dut.u_checker.fail_count, timed_out);
        if (errors == 0 && dut.u_checker.fail_count == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/rv_core.sv
// top of the five-stage pipeline, instantiate with reset_pc and connect word-wide memories
`timescale 1ns/1ps

module rv_core #(
    parameter rv_core_pkg::word_t reset_pc = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               rst_n,
    output rv_core_pkg::word_t imem_addr,
    input  rv_core_pkg::word_t imem_rdata,
    input  logic               imem_stall,
    output logic               dmem_read,
    output logic               dmem_write,
    output rv_core_pkg::word_t dmem_addr,
    output rv_core_pkg::word_t dmem_wdata,
    input  rv_core_pkg::word_t dmem_rdata,
    input  logic               dmem_stall
);
    import rv_core_pkg::*;

    logic     freeze;
    word_t    pc;
    word_t    if_pc;
    word_t    if_instr;
    reg_idx_t id_rs1;
    reg_idx_t id_rs2;
    reg_idx_t id_rd;
    ctrl_t    id_ctrl;
    word_t    id_imm;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    br_op_a;
    word_t    br_op_b;
    word_t    branch_target;
    logic     branch_taken;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    fwd_sel_t br_a;
    fwd_sel_t br_b;
    logic     load_stall;
    logic     branch_flush;
    id_ex_t   id_ex;
    id_ex_t   id_ex_d;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;
    word_t    alu_result;
    word_t    store_data;
    word_t    wb_value;

    // either memory busy holds the whole pipe
    assign freeze = imem_stall | dmem_stall;

    // ----------------------------------------------------------------------
    // IF
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else if (!freeze && !load_stall) begin
            pc <= branch_flush ? branch_target : pc + 32'd4;
        end
    end

    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_pc    <= '0;
            if_instr <= '0;
        end else if (!freeze && !load_stall) begin
            if (branch_flush) begin
                // all-zero word decodes as a no-op
                if_pc    <= '0;
                if_instr <= '0;
            end else begin
                if_pc    <= pc;
                if_instr <= imem_rdata;
            end
        end
    end

    // ----------------------------------------------------------------------
    // ID
    // ----------------------------------------------------------------------
    assign id_rs1 = if_instr[19:15];
    assign id_rs2 = if_instr[24:20];
    assign id_rd  = if_instr[11:7];

    rv_decoder u_decoder (
        .instr (if_instr),
        .ctrl  (id_ctrl),
        .imm   (id_imm)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (id_rs1),
        .rs2      (id_rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (mem_wb.reg_write),
        .rd       (mem_wb.rd),
        .rd_data  (wb_value)
    );

    rv_hazard_unit u_hazard (
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .id_ctrl      (id_ctrl),
        .id_ex        (id_ex),
        .ex_mem       (ex_mem),
        .mem_wb       (mem_wb),
        .branch_taken (branch_taken),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .br_a         (br_a),
        .br_b         (br_b),
        .load_stall   (load_stall),
        .branch_flush (branch_flush)
    );

    function automatic word_t br_pick(input fwd_sel_t sel, input word_t reg_val,
                                      input word_t ex_val, input word_t mem_val);
        case (sel)
            fwd_ex:  return ex_val;
            fwd_mem: return mem_val;
            default: return reg_val;
        endcase
    endfunction

    // branch resolved here, not-taken path already fetched
    always_comb begin
        br_op_a = br_pick(br_a, rs1_data, alu_result, ex_mem.alu_result);
        br_op_b = br_pick(br_b, rs2_data, alu_result, ex_mem.alu_result);
    end

    assign branch_taken  = id_ctrl.is_branch & ((br_op_a == br_op_b) ^ id_ctrl.branch_ne);
    assign branch_target = if_pc + id_imm;

    assign id_ex_d = '{ctrl: id_ctrl, rs1: id_rs1, rs2: id_rs2, rd: id_rd,
                       rs1_data: rs1_data, rs2_data: rs2_data, imm: id_imm};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (!freeze) begin
            // load-use bubble
            id_ex <= load_stall ? '0 : id_ex_d;
        end
    end

    // ----------------------------------------------------------------------
    // EX
    // ----------------------------------------------------------------------
    rv_execute u_execute (
        .id_ex      (id_ex),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .mem_result (ex_mem.alu_result),
        .wb_result  (wb_value),
        .alu_result (alu_result),
        .store_data (store_data)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (!freeze) begin
            ex_mem <= '{ctrl: id_ex.ctrl, rd: id_ex.rd,
                        alu_result: alu_result, store_data: store_data};
        end
    end

    // ----------------------------------------------------------------------
    // MEM and WB
    // ----------------------------------------------------------------------
    // requests stay put while frozen since ex_mem holds
    assign dmem_read  = ex_mem.ctrl.mem_read;
    assign dmem_write = ex_mem.ctrl.mem_write;
    assign dmem_addr  = ex_mem.alu_result;
    assign dmem_wdata = ex_mem.store_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else if (!freeze) begin
            mem_wb <= '{reg_write: ex_mem.ctrl.reg_write,
                        mem_to_reg: ex_mem.ctrl.mem_to_reg,
                        rd: ex_mem.rd,
                        alu_result: ex_mem.alu_result,
                        load_data: dmem_rdata};
        end
    end

    assign wb_value = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

// File: verilog/rv_core_pkg.sv
// shared types, ALU and opcode constants, and pipeline register layouts; import in each stage
package rv_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  alu_op_t;
    typedef logic [1:0]  fwd_sel_t;

    localparam alu_op_t alu_add = 3'd0;
    localparam alu_op_t alu_sub = 3'd1;
    localparam alu_op_t alu_and = 3'd2;
    localparam alu_op_t alu_or  = 3'd3;
    localparam alu_op_t alu_slt = 3'd4;

    // operand sources, fwd_ex only feeds the branch compare
    localparam fwd_sel_t fwd_none = 2'd0;
    localparam fwd_sel_t fwd_wb   = 2'd1;
    localparam fwd_sel_t fwd_mem  = 2'd2;
    localparam fwd_sel_t fwd_ex   = 2'd3;

    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_itype  = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src;
        alu_op_t alu_op;
        logic    is_branch;
        logic    branch_ne;
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        reg_idx_t rd;
        word_t    alu_result;
        word_t    store_data;
    } ex_mem_t;

    typedef struct packed {
        logic     reg_write;
        logic     mem_to_reg;
        reg_idx_t rd;
        word_t    alu_result;
        word_t    load_data;
    } mem_wb_t;

endpackage

// File: verilog/rv_decoder.sv
// ID-stage decoder, turns an instruction word into control bits and a sign-extended immediate
`timescale 1ns/1ps

module rv_decoder (
    input  rv_core_pkg::word_t instr,
    output rv_core_pkg::ctrl_t ctrl,
    output rv_core_pkg::word_t imm
);
    import rv_core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    alu_op_t    arith_op;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // funct3 mapping shared by register and immediate forms
    always_comb begin
        case (funct3)
            3'b010:  arith_op = alu_slt;
            3'b110:  arith_op = alu_or;
            3'b111:  arith_op = alu_and;
            default: arith_op = alu_add;
        endcase
    end

    always_comb begin
        ctrl = '0;
        imm  = '0;
        case (opcode)
            op_rtype: begin
                ctrl.reg_write = 1'b1;
                // bit 30 only selects sub for the register form
                ctrl.alu_op    = (funct3 == 3'b000 && instr[30]) ? alu_sub : arith_op;
            end
            op_itype: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = arith_op;
                imm            = {{20{instr[31]}}, instr[31:20]};
            end
            op_load: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_op     = alu_add;
                imm             = {{20{instr[31]}}, instr[31:20]};
            end
            op_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_add;
                imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            op_branch: begin
                ctrl.is_branch = 1'b1;
                // funct3 000 is beq, 001 is bne
                ctrl.branch_ne = funct3[0];
                imm            = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            default: begin
                // flush word and unsupported opcodes become a no-op
                ctrl = '0;
            end
        endcase
    end

endmodule

// File: verilog/rv_execute.sv
// EX stage, forwarded operand selection and the integer ALU
`timescale 1ns/1ps

module rv_execute (
    input  rv_core_pkg::id_ex_t   id_ex,
    input  rv_core_pkg::fwd_sel_t fwd_a,
    input  rv_core_pkg::fwd_sel_t fwd_b,
    input  rv_core_pkg::word_t    mem_result,
    input  rv_core_pkg::word_t    wb_result,
    output rv_core_pkg::word_t    alu_result,
    output rv_core_pkg::word_t    store_data
);
    import rv_core_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t rs2_val;

    function automatic word_t pick(input fwd_sel_t sel, input word_t reg_val,
                                   input word_t mem_val, input word_t wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        op_a    = pick(fwd_a, id_ex.rs1_data, mem_result, wb_result);
        rs2_val = pick(fwd_b, id_ex.rs2_data, mem_result, wb_result);
        op_b    = id_ex.ctrl.alu_src ? id_ex.imm : rs2_val;
    end

    // stores take rs2 after forwarding, never the immediate
    assign store_data = rs2_val;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_sub: begin
                alu_result = op_a - op_b;
            end
            alu_and: begin
                alu_result = op_a & op_b;
            end
            alu_or: begin
                alu_result = op_a | op_b;
            end
            alu_slt: begin
                alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            end
            default: begin
                alu_result = op_a + op_b;
            end
        endcase
    end

endmodule

// File: verilog/rv_hazard_unit.sv
// forwarding selects for EX and the ID branch compare, plus load-use stall and branch flush
`timescale 1ns/1ps

module rv_hazard_unit (
    input  rv_core_pkg::reg_idx_t id_rs1,
    input  rv_core_pkg::reg_idx_t id_rs2,
    input  rv_core_pkg::ctrl_t    id_ctrl,
    input  rv_core_pkg::id_ex_t   id_ex,
    input  rv_core_pkg::ex_mem_t  ex_mem,
    input  rv_core_pkg::mem_wb_t  mem_wb,
    input  logic                  branch_taken,
    output rv_core_pkg::fwd_sel_t fwd_a,
    output rv_core_pkg::fwd_sel_t fwd_b,
    output rv_core_pkg::fwd_sel_t br_a,
    output rv_core_pkg::fwd_sel_t br_b,
    output logic                  load_stall,
    output logic                  branch_flush
);
    import rv_core_pkg::*;

    logic uses_rs1;
    logic uses_rs2;
    logic ex_load_hit;
    logic mem_load_hit;

    function automatic logic hit(input logic wr, input reg_idx_t rd, input reg_idx_t rs);
        return wr && (rd != '0) && (rd == rs);
    endfunction

    // EX operands, newest producer first
    always_comb begin
        fwd_a = fwd_none;
        fwd_b = fwd_none;
        if (hit(ex_mem.ctrl.reg_write, ex_mem.rd, id_ex.rs1))
            fwd_a = fwd_mem;
        else if (hit(mem_wb.reg_write, mem_wb.rd, id_ex.rs1))
            fwd_a = fwd_wb;
        if (hit(ex_mem.ctrl.reg_write, ex_mem.rd, id_ex.rs2))
            fwd_b = fwd_mem;
        else if (hit(mem_wb.reg_write, mem_wb.rd, id_ex.rs2))
            fwd_b = fwd_wb;
    end

    // branch operands in ID, WB is covered by the register file bypass
    always_comb begin
        br_a = fwd_none;
        br_b = fwd_none;
        if (hit(id_ex.ctrl.reg_write, id_ex.rd, id_rs1))
            br_a = fwd_ex;
        else if (hit(ex_mem.ctrl.reg_write, ex_mem.rd, id_rs1))
            br_a = fwd_mem;
        if (hit(id_ex.ctrl.reg_write, id_ex.rd, id_rs2))
            br_b = fwd_ex;
        else if (hit(ex_mem.ctrl.reg_write, ex_mem.rd, id_rs2))
            br_b = fwd_mem;
    end

    assign uses_rs1 = id_ctrl.reg_write | id_ctrl.mem_write | id_ctrl.is_branch;
    assign uses_rs2 = (id_ctrl.reg_write & ~id_ctrl.alu_src) | id_ctrl.mem_write
                      | id_ctrl.is_branch;

    assign ex_load_hit  = hit(id_ex.ctrl.mem_read & uses_rs1, id_ex.rd, id_rs1)
                          | hit(id_ex.ctrl.mem_read & uses_rs2, id_ex.rd, id_rs2);
    // load data is not ready for a branch until the load reaches WB
    assign mem_load_hit = id_ctrl.is_branch
                          & (hit(ex_mem.ctrl.mem_read, ex_mem.rd, id_rs1)
                          | hit(ex_mem.ctrl.mem_read, ex_mem.rd, id_rs2));

    assign load_stall   = ex_load_hit | mem_load_hit;
    assign branch_flush = branch_taken & ~load_stall;

endmodule

// File: verilog/rv_regfile.sv
// integer register file, two read ports and one write port from WB, x0 reads as zero
`timescale 1ns/1ps

module rv_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_core_pkg::reg_idx_t rs1,
    input  rv_core_pkg::reg_idx_t rs2,
    output rv_core_pkg::word_t    rs1_data,
    output rv_core_pkg::word_t    rs2_data,
    input  logic                  we,
    input  rv_core_pkg::reg_idx_t rd,
    input  rv_core_pkg::word_t    rd_data
);
    import rv_core_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    // same-cycle write shows up on the read ports
    assign rs1_data = (rs1 == '0) ? '0 :
                      (we && rd == rs1) ? rd_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (we && rd == rs2) ? rd_data : regs[rs2];

endmodule
